/* include/heap_consts.svh */
//--------------------------------------
// Heap memory constants
// Field widths, array counts and the request action codes
//--------------------------------------
`ifndef HEAP_CONSTS_SVH
`define HEAP_CONSTS_SVH

`define HEAP_ARRAY_BITS   2                       // Bits in an array number
`define HEAP_INDEX_BITS   2                       // Four elements per array
`define HEAP_DATA_BITS    12                      // Element width
`define HEAP_ARRAYS       (1 << `HEAP_ARRAY_BITS) // Arrays in the heap
`define HEAP_LENGTH       (1 << `HEAP_INDEX_BITS) // Elements per array

// Action codes of the memory bus
`define HEAP_ACTION_BITS  8
`define HEAP_ACT_WRITE    8'd2
`define HEAP_ACT_READ     8'd3
`define HEAP_ACT_SIZE     8'd4
`define HEAP_ACT_SEARCH   8'd7
`define HEAP_ACT_PUSH     8'd14
`define HEAP_ACT_POP      8'd15
`define HEAP_ACT_ALLOC    8'd18
`define HEAP_ACT_FREE     8'd19
`define HEAP_ACT_ADD      8'd20
`define HEAP_ACT_ADDAFTER 8'd21
`define HEAP_ACT_SUB      8'd22
`define HEAP_ACT_SUBAFTER 8'd23
`define HEAP_ACT_OR       8'd28
`define HEAP_ACT_XOR      8'd29
`define HEAP_ACT_AND      8'd30

`endif

/* verilog/heapPkg.sv */
//--------------------------------------
// Heap memory types
// Field types, request actions and error codes shared by the stages
//--------------------------------------
`default_nettype none

`include "heap_consts.svh"

package heapPkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayId;      // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] elementIndex; // Index within an array
  typedef logic [`HEAP_INDEX_BITS:0]   arraySize;    // Zero up to full length
  typedef logic [`HEAP_DATA_BITS-1:0]  element;      // One data word

  // Requests the heap accepts
  typedef enum logic [`HEAP_ACTION_BITS-1:0] {
    actWrite    = `HEAP_ACT_WRITE,    // Write element, extend size
    actRead     = `HEAP_ACT_READ,
    actSize     = `HEAP_ACT_SIZE,
    actSearch   = `HEAP_ACT_SEARCH,   // Last match position plus one
    actPush     = `HEAP_ACT_PUSH,
    actPop      = `HEAP_ACT_POP,
    actAlloc    = `HEAP_ACT_ALLOC,
    actFree     = `HEAP_ACT_FREE,
    actAdd      = `HEAP_ACT_ADD,      // Returns new value
    actAddAfter = `HEAP_ACT_ADDAFTER, // Returns old value
    actSubtract = `HEAP_ACT_SUB,
    actSubAfter = `HEAP_ACT_SUBAFTER,
    actOrBits   = `HEAP_ACT_OR,
    actXorBits  = `HEAP_ACT_XOR,
    actAndBits  = `HEAP_ACT_AND
  } heapAction;

  // Outcome reported with each done pulse
  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,           // Array never allocated or freed
    errOutOfBounds  = 3'd2,           // Index at or above size
    errFull         = 3'd3,           // Push onto full array
    errEmpty        = 3'd4,           // Pop from empty array
    errOutOfMemory  = 3'd5            // No array left to allocate
  } heapError;

endpackage

`default_nettype wire

/* verilog/heapCheck.sv */
//--------------------------------------
// Heap check stage
// Tracks allocation, free stack and sizes, validates each request
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "heap_consts.svh"

module heapCheck (
  input  wire                       clock,
  input  wire                       resetN,
  input  wire                       request,
  input  wire heapPkg::heapAction   action,
  input  wire heapPkg::arrayId      array,
  input  wire heapPkg::elementIndex index,
  input  wire heapPkg::element      dataIn,
  output logic                      checkValid,
  output heapPkg::heapAction        checkAction,
  output heapPkg::arrayId           checkArray,
  output heapPkg::elementIndex      checkIndex,
  output heapPkg::element           checkData,
  output heapPkg::arraySize         checkSize,
  output heapPkg::heapError         checkError
);
  import heapPkg::*;

  logic [`HEAP_ARRAYS-1:0]   allocated;            // One bit per array
  arraySize                  sizes [`HEAP_ARRAYS];
  arrayId                    freeStack [`HEAP_ARRAYS];
  logic [`HEAP_ARRAY_BITS:0] freeTop;              // Entries on free stack
  logic [`HEAP_ARRAY_BITS:0] usedCount;            // Numbers ever handed out

  arraySize    curSize;
  arrayId      topEntry;
  logic        inBounds;
  arrayId      nextArray;
  elementIndex nextIndex;
  arraySize    nextSize;
  heapError    nextError;

  assign curSize  = sizes[array];
  assign topEntry = arrayId'(freeTop - 1'b1);
  assign inBounds = arraySize'(index) < curSize;

  //--------------------------------------
  // Request validation
  //--------------------------------------
  always_comb begin
    nextArray = array;
    nextIndex = index;
    nextSize  = curSize;
    nextError = errNone;
    if (action == actAlloc) begin
      nextSize = '0;                                 // New array starts empty
      if (freeTop != '0) begin
        nextArray = freeStack[topEntry];             // Reuse last freed
      end else if (usedCount < `HEAP_ARRAYS) begin
        nextArray = arrayId'(usedCount);             // Fresh number
      end else begin
        nextError = errOutOfMemory;
      end
    end else if (!allocated[array]) begin
      nextError = errNotAllocated;
    end else begin
      case (action)
        actWrite: begin
          if (!inBounds) begin
            nextSize = arraySize'(index) + 1'b1;     // Grow to cover index
          end
        end
        actRead, actAdd, actAddAfter, actSubtract, actSubAfter,
        actOrBits, actXorBits, actAndBits: begin
          if (!inBounds) begin
            nextError = errOutOfBounds;
          end
        end
        actPush: begin
          if (curSize == arraySize'(`HEAP_LENGTH)) begin
            nextError = errFull;
          end else begin
            nextIndex = elementIndex'(curSize);      // Slot past the top
            nextSize  = curSize + 1'b1;
          end
        end
        actPop: begin
          if (curSize == '0) begin
            nextError = errEmpty;
          end else begin
            nextSize  = curSize - 1'b1;
            nextIndex = elementIndex'(curSize - 1'b1); // Top element
          end
        end
        default: ;                                   // Size, search, free
      endcase
    end
  end

  //--------------------------------------
  // Allocation and size state
  //--------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      freeTop   <= '0;
      usedCount <= '0;
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else if (request && nextError == errNone) begin
      case (action)
        actAlloc: begin
          allocated[nextArray] <= 1'b1;
          if (freeTop != '0) begin
            freeTop <= freeTop - 1'b1;               // Pop free stack
          end else begin
            usedCount <= usedCount + 1'b1;
          end
        end
        actFree: begin
          allocated[array] <= 1'b0;
          freeTop          <= freeTop + 1'b1;
        end
        default: ;
      endcase
      sizes[nextArray] <= nextSize;                  // Unchanged unless resized
    end
  end

  always_ff @(posedge clock) begin
    if (request && action == actFree && nextError == errNone) begin
      freeStack[arrayId'(freeTop)] <= array;         // Push freed number
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      checkValid <= 1'b0;
    end else begin
      checkValid <= request;
    end
  end

  always_ff @(posedge clock) begin
    if (request) begin
      checkAction <= action;
      checkArray  <= nextArray;
      checkIndex  <= nextIndex;
      checkData   <= dataIn;
      checkSize   <= nextSize;
      checkError  <= nextError;
    end
  end

endmodule

`default_nettype wire

/* verilog/heapAccess.sv */
//--------------------------------------
// Heap access stage
// Element storage, element read and array search with forwarding
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "heap_consts.svh"

module heapAccess (
  input  wire                       clock,
  input  wire                       resetN,
  input  wire                       checkValid,
  input  wire heapPkg::heapAction   checkAction,
  input  wire heapPkg::arrayId      checkArray,
  input  wire heapPkg::elementIndex checkIndex,
  input  wire heapPkg::element      checkData,
  input  wire heapPkg::arraySize    checkSize,
  input  wire heapPkg::heapError    checkError,
  input  wire                       writeEnable,
  input  wire heapPkg::arrayId      writeArray,
  input  wire heapPkg::elementIndex writeIndex,
  input  wire heapPkg::element      writeData,
  output logic                      accessValid,
  output heapPkg::heapAction        accessAction,
  output heapPkg::arrayId           accessArray,
  output heapPkg::elementIndex      accessIndex,
  output heapPkg::element           accessData,
  output heapPkg::arraySize         accessSize,
  output heapPkg::heapError         accessError,
  output heapPkg::element           accessElement,
  output heapPkg::arraySize         accessFound
);
  import heapPkg::*;

  element   storage [`HEAP_ARRAYS][`HEAP_LENGTH]; // Every array's elements
  logic     forwardRow;                           // Execute writes this array
  element   readElement;
  arraySize found;

  assign forwardRow = writeEnable && (writeArray == checkArray);

  //--------------------------------------
  // Read and search
  //--------------------------------------
  always_comb begin
    element value;
    if (forwardRow && writeIndex == checkIndex) begin
      readElement = writeData;                     // Write still in flight
    end else begin
      readElement = storage[checkArray][checkIndex];
    end
    found = '0;
    for (int i = 0; i < `HEAP_LENGTH; i++) begin
      if (forwardRow && writeIndex == elementIndex'(i)) begin
        value = writeData;
      end else begin
        value = storage[checkArray][i];
      end
      if (arraySize'(i) < checkSize && value == checkData) begin
        found = arraySize'(i + 1);                 // Highest match wins
      end
    end
  end

  // Write back from execute lands one edge later
  always_ff @(posedge clock) begin
    if (writeEnable) begin
      storage[writeArray][writeIndex] <= writeData;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      accessValid <= 1'b0;
    end else begin
      accessValid <= checkValid;
    end
  end

  always_ff @(posedge clock) begin
    if (checkValid) begin
      accessAction  <= checkAction;
      accessArray   <= checkArray;
      accessIndex   <= checkIndex;
      accessData    <= checkData;
      accessSize    <= checkSize;
      accessError   <= checkError;
      accessElement <= readElement;
      accessFound   <= found;
    end
  end

endmodule

`default_nettype wire

/* verilog/heapExecute.sv */
//--------------------------------------
// Heap execute stage
// Element update, write back and result selection
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapExecute (
  input  wire                       clock,
  input  wire                       resetN,
  input  wire                       accessValid,
  input  wire heapPkg::heapAction   accessAction,
  input  wire heapPkg::arrayId      accessArray,
  input  wire heapPkg::elementIndex accessIndex,
  input  wire heapPkg::element      accessData,
  input  wire heapPkg::arraySize    accessSize,
  input  wire heapPkg::heapError    accessError,
  input  wire heapPkg::element      accessElement,
  input  wire heapPkg::arraySize    accessFound,
  output logic                      writeEnable,
  output heapPkg::arrayId           writeArray,
  output heapPkg::elementIndex      writeIndex,
  output heapPkg::element           writeData,
  output logic                      done,
  output heapPkg::element           dataOut,
  output heapPkg::heapError         error
);
  import heapPkg::*;

  element newValue;
  logic   updates;                                 // Action stores an element
  element result;

  always_comb begin
    newValue = accessData;                         // Write and push store data
    updates  = 1'b1;
    case (accessAction)
      actWrite, actPush:        ;
      actAdd, actAddAfter:      newValue = accessElement + accessData;
      actSubtract, actSubAfter: newValue = accessElement - accessData;
      actOrBits:                newValue = accessElement | accessData;
      actXorBits:               newValue = accessElement ^ accessData;
      actAndBits:               newValue = accessElement & accessData;
      default:                  updates  = 1'b0;
    endcase
  end

  assign writeEnable = accessValid && updates && accessError == errNone;
  assign writeArray  = accessArray;
  assign writeIndex  = accessIndex;
  assign writeData   = newValue;

  //--------------------------------------
  // Result
  //--------------------------------------
  always_comb begin
    result = '0;                                   // Free, push, any error
    if (accessError == errNone) begin
      case (accessAction)
        actAlloc:                 result = element'(accessArray);
        actWrite:                 result = accessData;
        actRead, actPop:          result = accessElement;
        actSize:                  result = element'(accessSize);
        actSearch:                result = element'(accessFound);
        actAddAfter, actSubAfter: result = accessElement; // Value before update
        actAdd, actSubtract, actOrBits, actXorBits, actAndBits:
                                  result = newValue;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done    <= 1'b0;
      dataOut <= '0;
      error   <= errNone;
    end else begin
      done <= accessValid;
      if (accessValid) begin
        dataOut <= result;
        error   <= accessError;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/heapMemory.sv */
//--------------------------------------
// Heap memory top
// Check, access and execute stages in a three cycle pipeline
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapMemory (
  input  wire                       clock,
  input  wire                       resetN,
  input  wire                       request,
  input  wire heapPkg::heapAction   action,
  input  wire heapPkg::arrayId      array,
  input  wire heapPkg::elementIndex index,
  input  wire heapPkg::element      dataIn,
  output wire                       done,
  output wire heapPkg::element      dataOut,
  output wire heapPkg::heapError    error
);
  import heapPkg::*;

  // Check to access
  wire              checkValid;
  wire heapAction   checkAction;
  wire arrayId      checkArray;
  wire elementIndex checkIndex;
  wire element      checkData;
  wire arraySize    checkSize;
  wire heapError    checkError;

  // Access to execute
  wire              accessValid;
  wire heapAction   accessAction;
  wire arrayId      accessArray;
  wire elementIndex accessIndex;
  wire element      accessData;
  wire arraySize    accessSize;
  wire heapError    accessError;
  wire element      accessElement;
  wire arraySize    accessFound;

  // Write back from execute
  wire              writeEnable;
  wire arrayId      writeArray;
  wire elementIndex writeIndex;
  wire element      writeData;

  heapCheck u_check (.*);
  heapAccess u_access (.*);
  heapExecute u_execute (.*);

endmodule

`default_nettype wire

/* dv/heapClock.sv */
//--------------------------------------
// Heap testbench clock
// 20 ns clock, reset held low for 8 cycles
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapClock (
  output logic clock,
  output logic resetN
);

  initial begin
    clock  = 1'b0;
    resetN = 1'b0;
    repeat (8) @(posedge clock);
    #1 resetN = 1'b1;                              // Release just after an edge
  end

  always #10 clock = ~clock;

endmodule

`default_nettype wire

/* dv/heapTb.sv */
//--------------------------------------
// Heap memory testbench
// Reference model, directed and random stimulus, assertion checks
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "heap_consts.svh"

module heapTb;
  import heapPkg::*;

  localparam int cycleLimit = 400;

  wire         clock;
  wire         resetN;
  logic        request;
  heapAction   action;
  arrayId      array;
  elementIndex index;
  element      dataIn;
  wire         done;
  element      dataOut;
  heapError    error;

  // Reference model state
  logic [`HEAP_ARRAYS-1:0] modelAlloc;
  int       modelSize [`HEAP_ARRAYS];
  int       modelFree [`HEAP_ARRAYS];
  int       modelFreeTop;
  int       modelUsed;
  element   modelMem [`HEAP_ARRAYS][`HEAP_LENGTH];
  element   dataQueue [$];
  heapError errorQueue [$];
  element   expData;
  heapError expError;

  int        valueErrors;
  int        timingErrors;
  int        otherErrors;
  int        cycles;
  integer    seed;
  element    pushed [`HEAP_LENGTH];
  heapAction updateOps [7] = '{actAdd, actAddAfter, actSubtract, actSubAfter,
                               actOrBits, actXorBits, actAndBits};

  heapClock u_clock (.clock(clock), .resetN(resetN));

  heapMemory u_dut (
    .clock(clock), .resetN(resetN), .request(request), .action(action),
    .array(array), .index(index), .dataIn(dataIn),
    .done(done), .dataOut(dataOut), .error(error)
  );

  function automatic element applyOp(heapAction act, element old, element operand);
    case (act)
      actAdd, actAddAfter:      applyOp = old + operand;
      actSubtract, actSubAfter: applyOp = old - operand;
      actOrBits:                applyOp = old | operand;
      actXorBits:               applyOp = old ^ operand;
      default:                  applyOp = old & operand;
    endcase
  endfunction

  // Apply one request to the model and queue its expected result
  task automatic predict(heapAction act, arrayId arr, elementIndex idx, element data);
    element   result;
    heapError err;
    int       id;
    int       found;
    result = '0;
    err    = errNone;
    if (act == actAlloc) begin
      id = -1;
      if (modelFreeTop > 0) begin
        modelFreeTop--;
        id = modelFree[modelFreeTop];              // Last freed comes back first
      end else if (modelUsed < `HEAP_ARRAYS) begin
        id = modelUsed;
        modelUsed++;
      end else begin
        err = errOutOfMemory;
      end
      if (id >= 0) begin
        modelAlloc[id] = 1'b1;
        modelSize[id]  = 0;
        result         = element'(id);
      end
    end else if (!modelAlloc[arr]) begin
      err = errNotAllocated;
    end else begin
      case (act)
        actWrite: begin
          modelMem[arr][idx] = data;
          if (int'(idx) + 1 > modelSize[arr]) modelSize[arr] = int'(idx) + 1;
          result = data;
        end
        actRead: begin
          if (int'(idx) >= modelSize[arr]) err = errOutOfBounds;
          else result = modelMem[arr][idx];
        end
        actSize: result = element'(modelSize[arr]);
        actSearch: begin
          found = 0;
          for (int i = 0; i < modelSize[arr]; i++) begin
            if (modelMem[arr][i] == data) found = i + 1;
          end
          result = element'(found);
        end
        actPush: begin
          if (modelSize[arr] == `HEAP_LENGTH) begin
            err = errFull;
          end else begin
            modelMem[arr][modelSize[arr]] = data;
            modelSize[arr]++;
          end
        end
        actPop: begin
          if (modelSize[arr] == 0) begin
            err = errEmpty;
          end else begin
            modelSize[arr]--;
            result = modelMem[arr][modelSize[arr]];
          end
        end
        actFree: begin
          modelAlloc[arr]          = 1'b0;
          modelFree[modelFreeTop] = int'(arr);
          modelFreeTop++;
        end
        default: begin                             // Element updates
          if (int'(idx) >= modelSize[arr]) begin
            err = errOutOfBounds;
          end else begin
            result = applyOp(act, modelMem[arr][idx], data);
            if (act == actAddAfter || act == actSubAfter) result = modelMem[arr][idx];
            modelMem[arr][idx] = applyOp(act, modelMem[arr][idx], data);
          end
        end
      endcase
    end
    dataQueue.push_back(result);
    errorQueue.push_back(err);
  endtask

  // Drive one request for a cycle and leave request high for the next call
  task automatic sendRequest(heapAction act, arrayId arr, elementIndex idx, element data);
    predict(act, arr, idx, data);
    request = 1'b1;
    action  = act;
    array   = arr;
    index   = idx;
    dataIn  = data;
    @(posedge clock);
    #1;
  endtask

  task automatic idleCycle();
    request = 1'b0;
    @(posedge clock);
    #1;
  endtask

  //--------------------------------------
  // Checks
  //--------------------------------------
  always @(negedge clock) begin
    if (done) begin
      if (dataQueue.size() == 0) begin
        otherErrors++;
        $display("Done pulse at %0t with no request outstanding", $time);
      end else begin
        expData  = dataQueue.pop_front();
        expError = errorQueue.pop_front();
      end
    end
  end

  assert property (@(posedge clock) disable iff (!resetN) done == $past(request, 3))
    else begin
      timingErrors++;
      $display("Done pulse out of step with the requests at %0t", $time);
    end

  assert property (@(posedge clock) disable iff (!resetN)
                   done |-> (dataOut == expData && error == expError))
    else begin
      valueErrors++;
      $display("Fail %0t: result %h error %0d, expected %h error %0d", $time,
               $sampled(dataOut), $sampled(error), expData, expError);
    end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("Timeout after %0d cycles, results still outstanding", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  //--------------------------------------
  // Stimulus
  //--------------------------------------
  initial begin
    request = 1'b0;
    action  = actSize;
    array   = '0;
    index   = '0;
    dataIn  = '0;
    seed    = 65704;
    modelAlloc   = '0;
    modelFreeTop = 0;
    modelUsed    = 0;
    expData      = '0;
    expError     = errNone;
    valueErrors  = 0;
    timingErrors = 0;
    otherErrors  = 0;
    cycles       = 0;
    for (int i = 0; i < `HEAP_ARRAYS; i++) modelSize[i] = 0;
    @(posedge resetN);
    @(posedge clock);
    #1;

    sendRequest(actRead, 2'd0, 2'd0, '0);           // Never allocated
    // Allocation order and reuse from the free stack
    for (int i = 0; i < 5; i++) sendRequest(actAlloc, 2'd0, 2'd0, '0);
    sendRequest(actFree, 2'd2, 2'd0, '0);
    sendRequest(actFree, 2'd1, 2'd0, '0);
    sendRequest(actAlloc, 2'd0, 2'd0, '0);
    sendRequest(actAlloc, 2'd0, 2'd0, '0);

    // Freed array, bounds and size growth
    sendRequest(actFree, 2'd3, 2'd0, '0);
    sendRequest(actRead, 2'd3, 2'd0, '0);
    sendRequest(actWrite, 2'd3, 2'd1, 12'h111);
    sendRequest(actWrite, 2'd0, 2'd1, element'($random(seed)));
    sendRequest(actSize, 2'd0, 2'd0, '0);
    sendRequest(actRead, 2'd0, 2'd2, '0);
    sendRequest(actRead, 2'd0, 2'd3, '0);
    sendRequest(actRead, 2'd0, 2'd1, '0);
    sendRequest(actAlloc, 2'd0, 2'd0, '0);          // Array 3 back again

    // Stack behaviour on array 1
    for (int i = 0; i < `HEAP_LENGTH; i++) pushed[i] = element'($random(seed));
    for (int i = 0; i < `HEAP_LENGTH; i++) sendRequest(actPush, 2'd1, 2'd0, pushed[i]);
    sendRequest(actPush, 2'd1, 2'd0, 12'h555);
    for (int i = 0; i <= `HEAP_LENGTH; i++) sendRequest(actPop, 2'd1, 2'd0, '0);

    // Search on array 2
    sendRequest(actWrite, 2'd2, 2'd0, 12'd10);
    sendRequest(actWrite, 2'd2, 2'd1, 12'd20);
    sendRequest(actWrite, 2'd2, 2'd2, 12'd20);
    sendRequest(actWrite, 2'd2, 2'd3, 12'd30);
    sendRequest(actSearch, 2'd2, 2'd0, 12'd20);
    sendRequest(actSearch, 2'd2, 2'd0, 12'd99);
    idleCycle();

    // Random element updates on array 3
    for (int i = 0; i < `HEAP_LENGTH; i++) begin
      sendRequest(actWrite, 2'd3, elementIndex'(i), element'($random(seed)));
    end
    for (int round = 0; round < 3; round++) begin
      foreach (updateOps[k]) begin
        sendRequest(updateOps[k], 2'd3, elementIndex'($random(seed)),
                    element'($random(seed)));
      end
    end
    idleCycle();

    // Back to back on one element to exercise forwarding
    sendRequest(actWrite, 2'd0, 2'd0, element'($random(seed)));
    sendRequest(actRead, 2'd0, 2'd0, '0);
    sendRequest(actAdd, 2'd0, 2'd0, element'($random(seed)));
    sendRequest(actRead, 2'd0, 2'd0, '0);
    idleCycle();

    while (dataQueue.size() != 0) @(posedge clock);
    repeat (2) @(posedge clock);
    $display("Errors: value %0d, timing %0d, other %0d",
             valueErrors, timingErrors, otherErrors);
    if (valueErrors + timingErrors + otherErrors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* heapMemory.f */
+incdir+include
verilog/heapPkg.sv
verilog/heapCheck.sv
verilog/heapAccess.sv
verilog/heapExecute.sv
verilog/heapMemory.sv
dv/heapClock.sv
dv/heapTb.sv

/* run.sh */
#!/bin/sh
# Build and run the heap memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module heapTb -Mdir obj_dir -f heapMemory.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/VheapTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Test OK"; then
  exit 0
fi
exit 1
